// File: hdl/afu_pkg.sv
// Shared definitions for the MMIO line-sum accelerator
// Holds the widths, the CSR map, the FIFO depth, the port structs and the
// sum engine state type. Every RTL block takes it by a wildcard import
package afu_pkg;

    // ====================
    // Widths
    // ====================

    localparam int WORD_W         = 64;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int WORD_BYTES     = WORD_W / 8;
    localparam int LINE_BYTES     = LINE_W / 8;
    localparam int CSR_ADDR_W     = 4;
    localparam int LINE_ADDR_W    = 6;
    localparam int COUNT_W        = 32;
    localparam int SEQ_W          = 8;

    // The FIFO depth doubles as the number of credits the ingress starts with
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int LEVEL_W    = $clog2(FIFO_DEPTH + 1);

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [WORD_BYTES-1:0]  word_be_t;
    typedef logic [LINE_BYTES-1:0]  line_be_t;
    typedef logic [CSR_ADDR_W-1:0]  csr_addr_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [COUNT_W-1:0]     count_t;
    typedef logic [SEQ_W-1:0]       seq_t;
    typedef logic [PTR_W-1:0]       ptr_t;
    // Counts from 0 up to FIFO_DEPTH inclusive, used for credits and fill level
    typedef logic [LEVEL_W-1:0]     level_t;

    // ====================
    // Address map
    // ====================

    // Only this word address of the wide port carries lines
    localparam line_addr_t LINE_WINDOW_ADDR = 6'h00;

    localparam word_t AFU_ID = 64'h4c53_554d_0001_0a01;

    localparam csr_addr_t CSR_ID      = 4'd0;
    localparam csr_addr_t CSR_SCRATCH = 4'd1;
    localparam csr_addr_t CSR_CTRL    = 4'd2;
    localparam csr_addr_t CSR_SUM     = 4'd3;
    localparam csr_addr_t CSR_LINES   = 4'd4;
    localparam csr_addr_t CSR_DROPS   = 4'd5;
    localparam csr_addr_t CSR_REJECTS = 4'd6;

    // Pause is a level, clear is a self-clearing strobe
    localparam int CTRL_PAUSE_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;

    // ====================
    // Port structs
    // ====================

    typedef struct packed {
        csr_addr_t address;
        logic      read;
        logic      write;
        word_t     writedata;
        word_be_t  byteenable;
    } mmio64_req_t;

    typedef struct packed {
        word_t readdata;
        logic  readdatavalid;
    } mmio64_rsp_t;

    typedef struct packed {
        line_addr_t address;
        logic       write;
        line_t      writedata;
        line_be_t   byteenable;
    } mmio512_wr_t;

    typedef struct packed {
        logic  valid;
        seq_t  seq;
        line_t data;
    } line_pkt_t;

    typedef enum logic [1:0] {
        IDLE,
        SUM,
        PAUSED
    } eng_state_t;

endpackage

// File: hdl/mmio512_ingress.sv
// Producer side of the line path
// Checks each 512-bit MMIO write, spends a credit on every accepted line and
// sends it to the line FIFO with a sequence tag. Lines with no credit are
// dropped and counted, malformed writes are rejected and counted
`timescale 1ns/1ps

module mmio512_ingress import afu_pkg::*; (
    input  logic        afu_clk,
    input  logic        rst_n,
    input  mmio512_wr_t wr,
    input  logic        clear,
    input  logic        credit_return,
    output line_pkt_t   pkt,
    output count_t      drops,
    output count_t      rejects
);

    logic   well_formed;
    logic   send;
    logic   drop;
    logic   reject;
    level_t credits;
    seq_t   next_seq;
    logic   pkt_valid;
    seq_t   pkt_seq;
    line_t  pkt_data;

    // A line must hit the window address with every byte lane enabled
    assign well_formed = (wr.address == LINE_WINDOW_ADDR) && (&wr.byteenable);

    // MMIO writes cannot be stalled, so a good line is either sent or dropped
    assign send   = wr.write && well_formed && (credits != '0);
    assign drop   = wr.write && well_formed && (credits == '0);
    assign reject = wr.write && !well_formed;

    // ====================
    // Credit pool
    // ====================

    // One credit leaves with each sent line and comes back when the FIFO pops it
    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            credits <= level_t'(FIFO_DEPTH);
        end else begin
            credits <= credits - level_t'(send) + level_t'(credit_return);
        end
    end

    // ====================
    // Outgoing packet
    // ====================

    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= send;
        end
    end

    // Payload only moves on a send
    always_ff @(posedge afu_clk) begin
        if (send) begin
            pkt_seq  <= next_seq;
            pkt_data <= wr.writedata;
        end
    end

    assign pkt = '{valid: pkt_valid, seq: pkt_seq, data: pkt_data};

    // ====================
    // Counters
    // ====================

    // Clear restarts the counts and the tags but never touches the credits,
    // since lines may still be in flight. An event in the clear cycle still counts
    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            drops    <= '0;
            rejects  <= '0;
            next_seq <= '0;
        end else if (clear) begin
            drops    <= count_t'(drop);
            rejects  <= count_t'(reject);
            next_seq <= '0;
        end else begin
            drops   <= drops + count_t'(drop);
            rejects <= rejects + count_t'(reject);
            if (send) begin
                next_seq <= next_seq + 1'b1;
            end
        end
    end

    // The FIFO hands back each credit exactly once per pop, so the pool can
    // never grow past the depth it started with
    a_credit_bound: assert property (@(posedge afu_clk) disable iff (!rst_n)
        credits <= level_t'(FIFO_DEPTH));

endmodule

// File: hdl/line_fifo.sv
// Line buffer between the ingress and the sum engine
// A circular buffer with a registered head entry. Each pop frees a slot and
// returns one credit to the ingress on the following cycle
`timescale 1ns/1ps

module line_fifo import afu_pkg::*; (
    input  logic      afu_clk,
    input  logic      rst_n,
    input  line_pkt_t pkt,
    input  logic      pop,
    output logic      head_valid,
    output line_pkt_t head_pkt,
    output logic      credit_return
);

    line_pkt_t mem [FIFO_DEPTH];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    level_t    mem_count;
    level_t    occupancy;
    logic      push;
    logic      head_free;
    logic      load_mem;
    logic      bypass;
    logic      write_mem;
    logic      head_valid_q;
    line_pkt_t head_q;

    assign push = pkt.valid;

    // The head slot can take a new entry when empty or when it is popped now
    assign head_free = !head_valid_q || pop;

    // Refill the head from storage first to keep order
    assign load_mem = head_free && (mem_count != '0);

    // With nothing stored the incoming line goes straight to the head
    assign bypass    = head_free && (mem_count == '0) && push;
    assign write_mem = push && !bypass;

    // Entries held in total, counting the head
    assign occupancy = mem_count + level_t'(head_valid_q);

    // ====================
    // Storage
    // ====================

    always_ff @(posedge afu_clk) begin
        if (write_mem) begin
            mem[wr_ptr] <= pkt;
        end
    end

    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_count <= '0;
        end else begin
            // Pointers wrap on their own since the depth is a power of two
            if (write_mem) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            mem_count <= mem_count + level_t'(write_mem) - level_t'(load_mem);
        end
    end

    // ====================
    // Head register
    // ====================

    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            head_valid_q  <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            if (head_free) begin
                head_valid_q <= load_mem || bypass;
            end
            credit_return <= pop;
        end
    end

    always_ff @(posedge afu_clk) begin
        if (load_mem) begin
            head_q <= mem[rd_ptr];
        end else if (bypass) begin
            head_q <= pkt;
        end
    end

    assign head_valid = head_valid_q;
    assign head_pkt   = '{valid: head_valid_q, seq: head_q.seq, data: head_q.data};

    // The ingress only sends while it holds a credit, which keeps a push
    // from ever landing on a full buffer
    a_no_push_full: assert property (@(posedge afu_clk) disable iff (!rst_n)
        push |-> (occupancy < level_t'(FIFO_DEPTH)));

    // The engine must only consume a head that is really there
    a_no_pop_empty: assert property (@(posedge afu_clk) disable iff (!rst_n)
        pop |-> head_valid_q);

endmodule

// File: hdl/line_sum_engine.sv
// Consumer side of the line path
// Pops lines from the FIFO head, adds their eight words into a running
// 64-bit sum and counts them. Holds off while the host has it paused
`timescale 1ns/1ps

module line_sum_engine import afu_pkg::*; (
    input  logic      afu_clk,
    input  logic      rst_n,
    input  logic      head_valid,
    input  line_pkt_t head_pkt,
    input  logic      pause,
    input  logic      clear,
    output logic      pop,
    output word_t     sum,
    output count_t    lines
);

    eng_state_t state;
    eng_state_t state_next;
    word_t      line_total;

    // Sum of all words in a line, wrapping at 64 bits
    function automatic word_t add_words(line_t data);
        word_t acc;
        acc = '0;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            acc = acc + data[i*WORD_W +: WORD_W];
        end
        return acc;
    endfunction

    assign line_total = add_words(head_pkt.data);

    // ====================
    // State machine
    // ====================

    // Pause is checked here too so a pause raised mid-stream stops popping at once
    assign pop = (state == SUM) && head_valid && !pause;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (pause) begin
                    state_next = PAUSED;
                end else if (head_valid) begin
                    state_next = SUM;
                end
            end
            SUM: begin
                // Stay here while lines keep coming, one pop per cycle
                if (pause) begin
                    state_next = PAUSED;
                end else if (!head_valid) begin
                    state_next = IDLE;
                end
            end
            PAUSED: begin
                if (!pause) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ====================
    // Accumulators
    // ====================

    // A line popped in the clear cycle becomes the first term after the clear
    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            sum   <= '0;
            lines <= '0;
        end else if (clear) begin
            sum   <= pop ? line_total : '0;
            lines <= count_t'(pop);
        end else if (pop) begin
            sum   <= sum + line_total;
            lines <= lines + 1'b1;
        end
    end

    // One cycle after pause is seen the engine is either still gated or
    // already parked in PAUSED, so no line may leave the FIFO
    a_no_pop_paused: assert property (@(posedge afu_clk) disable iff (!rst_n)
        pause |=> !pop);

endmodule

// File: hdl/csr_mmio64.sv
// Control and status registers on the 64-bit MMIO port
// Reads return one cycle after the request. Holds the scratch register and
// the control register, and exposes the engine and ingress counters
`timescale 1ns/1ps

module csr_mmio64 import afu_pkg::*; (
    input  logic        afu_clk,
    input  logic        rst_n,
    input  mmio64_req_t req,
    output mmio64_rsp_t rsp,
    input  word_t       sum,
    input  count_t      lines,
    input  count_t      drops,
    input  count_t      rejects,
    output logic        pause,
    output logic        clear
);

    word_t scratch;
    word_t rd_mux;
    word_t rdata_q;
    logic  rvalid_q;
    logic  scratch_wr;
    logic  ctrl_wr;

    assign scratch_wr = req.write && (req.address == CSR_SCRATCH);

    // The control bits all sit in the low byte, so that lane has to be enabled
    assign ctrl_wr = req.write && (req.address == CSR_CTRL) && req.byteenable[0];

    // ====================
    // Writes
    // ====================

    // Scratch only takes the enabled byte lanes
    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (scratch_wr) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (req.byteenable[b]) begin
                    scratch[b*8 +: 8] <= req.writedata[b*8 +: 8];
                end
            end
        end
    end

    // Pause holds its value, clear is a pulse that lasts a single cycle
    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            pause <= 1'b0;
            clear <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                pause <= req.writedata[CTRL_PAUSE_BIT];
            end
            clear <= ctrl_wr && req.writedata[CTRL_CLEAR_BIT];
        end
    end

    // ====================
    // Reads
    // ====================

    always_comb begin
        case (req.address)
            CSR_ID:      rd_mux = AFU_ID;
            CSR_SCRATCH: rd_mux = scratch;
            // Clear always reads back as zero
            CSR_CTRL:    rd_mux = word_t'(pause);
            CSR_SUM:     rd_mux = sum;
            CSR_LINES:   rd_mux = word_t'(lines);
            CSR_DROPS:   rd_mux = word_t'(drops);
            CSR_REJECTS: rd_mux = word_t'(rejects);
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge afu_clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req.read;
        end
    end

    // Read data is captured only with a read
    always_ff @(posedge afu_clk) begin
        if (req.read) begin
            rdata_q <= rd_mux;
        end
    end

    assign rsp = '{readdata: rdata_q, readdatavalid: rvalid_q};

endmodule

// File: hdl/mmio_afu_top.sv
// Top level of the line-sum accelerator
// Connects the 64-bit CSR port and the 512-bit write port to the ingress,
// the line FIFO, the sum engine and the CSR block
`timescale 1ns/1ps

module mmio_afu_top import afu_pkg::*; (
    input  logic        afu_clk,
    input  logic        rst_n,
    input  mmio64_req_t mmio64_req,
    output mmio64_rsp_t mmio64_rsp,
    input  mmio512_wr_t mmio512_wr
);

    // ====================
    // Internal wiring
    // ====================

    // Credit channel from the ingress into the FIFO
    line_pkt_t in_pkt;
    logic      credit_return;

    // Pop handshake between the FIFO head and the engine
    logic      head_valid;
    line_pkt_t head_pkt;
    logic      pop;

    // Control and status between the CSR block and the datapath
    logic      pause;
    logic      clear;
    word_t     sum;
    count_t    lines;
    count_t    drops;
    count_t    rejects;

    mmio512_ingress u_ingress (
        .afu_clk       (afu_clk),
        .rst_n         (rst_n),
        .wr            (mmio512_wr),
        .clear         (clear),
        .credit_return (credit_return),
        .pkt           (in_pkt),
        .drops         (drops),
        .rejects       (rejects)
    );

    line_fifo u_fifo (
        .afu_clk       (afu_clk),
        .rst_n         (rst_n),
        .pkt           (in_pkt),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_pkt      (head_pkt),
        .credit_return (credit_return)
    );

    line_sum_engine u_engine (
        .afu_clk    (afu_clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_pkt   (head_pkt),
        .pause      (pause),
        .clear      (clear),
        .pop        (pop),
        .sum        (sum),
        .lines      (lines)
    );

    csr_mmio64 u_csr (
        .afu_clk (afu_clk),
        .rst_n   (rst_n),
        .req     (mmio64_req),
        .rsp     (mmio64_rsp),
        .sum     (sum),
        .lines   (lines),
        .drops   (drops),
        .rejects (rejects),
        .pause   (pause),
        .clear   (clear)
    );

endmodule

// File: tests/tb_mmio_afu_tasks.svh
// Bus driver tasks and typed compare tasks for the line-sum accelerator testbench
// Included inside the testbench module, so the tasks drive its port signals
// directly and use its reference model state
`ifndef TB_MMIO_AFU_TASKS_SVH
`define TB_MMIO_AFU_TASKS_SVH

// ====================
// Compare tasks
// ====================

task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        stop_on_failure();
    end
endtask

task automatic check_count(input string what, input count_t got, input count_t exp);
    if (got !== exp) begin
        $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        stop_on_failure();
    end
endtask

// ====================
// Bus drivers
// ====================

// One write cycle on the CSR port, driven between falling edges
task automatic csr_write(input csr_addr_t addr, input word_t data, input word_be_t be);
    @(negedge afu_clk);
    mmio64_req.address    = addr;
    mmio64_req.writedata  = data;
    mmio64_req.byteenable = be;
    mmio64_req.write      = 1'b1;
    @(negedge afu_clk);
    mmio64_req.write = 1'b0;
endtask

// Read data must be valid exactly one cycle after the request
task automatic csr_read(input csr_addr_t addr, output word_t data);
    @(negedge afu_clk);
    mmio64_req.address = addr;
    mmio64_req.read    = 1'b1;
    @(negedge afu_clk);
    mmio64_req.read = 1'b0;
    if (!mmio64_rsp.readdatavalid) begin
        $display("CSR read of address %0d got no readdatavalid one cycle later", addr);
        stop_on_failure();
    end
    data = mmio64_rsp.readdata;
endtask

// The wide port has no waitrequest, so a write always lasts one cycle
task automatic line_write(input line_addr_t addr, input line_t data, input line_be_t be);
    @(negedge afu_clk);
    mmio512_wr.address    = addr;
    mmio512_wr.writedata  = data;
    mmio512_wr.byteenable = be;
    mmio512_wr.write      = 1'b1;
    @(negedge afu_clk);
    mmio512_wr.write = 1'b0;
endtask

// Polls the line count until the engine has taken every expected line
task automatic wait_lines(input count_t exp);
    word_t rd;
    bit    reached;
    reached = 1'b0;
    for (int t = 0; t < DRAIN_TRIES && !reached; t++) begin
        csr_read(CSR_LINES, rd);
        reached = (count_t'(rd) == exp);
    end
    if (!reached) begin
        $display("Line count never reached %0d, last read was %0d", exp, count_t'(rd));
        stop_on_failure();
    end
endtask

`endif

// File: tests/tb_mmio_afu.sv
// Testbench for the MMIO line-sum accelerator
// Drives both MMIO ports with random lines and CSR traffic from a fixed seed
// and checks the CSR view against a reference model of sum, lines, drops
// and rejects. Compile with the file list, top module tb_mmio_afu
`timescale 1ns/1ps

module tb_mmio_afu import afu_pkg::*; ();

    // Roughly ten times the length of the whole run
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int DRAIN_TRIES    = 32;
    localparam int LINES_RUNNING  = 20;
    localparam int LINES_OVERFLOW = FIFO_DEPTH + 5;

    logic        afu_clk;
    logic        rst_n;
    mmio64_req_t mmio64_req;
    mmio64_rsp_t mmio64_rsp;
    mmio512_wr_t mmio512_wr;

    int seed   = 3379;
    int cycles = 0;

    // Reference model state
    word_t  exp_sum;
    count_t exp_lines;
    count_t exp_drops;
    count_t exp_rejects;
    int     model_credits;

    mmio_afu_top dut (
        .afu_clk    (afu_clk),
        .rst_n      (rst_n),
        .mmio64_req (mmio64_req),
        .mmio64_rsp (mmio64_rsp),
        .mmio512_wr (mmio512_wr)
    );

    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    `include "tb_mmio_afu_tasks.svh"

    // ====================
    // Reference model
    // ====================

    // Adds the eight 64-bit words of a line, wrapping at 2^64
    function automatic word_t line_word_sum(input line_t data);
        word_t words [WORDS_PER_LINE];
        word_t total;
        total = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            words[w] = data[w*64 +: 64];
            total    = total + words[w];
        end
        return total;
    endfunction

    // Byte lanes with their enable bit set take the new value
    function automatic word_t merge_bytes(input word_t old, input word_t nxt, input word_be_t be);
        word_t res;
        res = old;
        for (int b = 0; b < 8; b++) begin
            if (be[b]) res[b*8 +: 8] = nxt[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < 16; i++) begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    // A good line is summed while a credit is left, else it is dropped
    task automatic send_line(input line_t data);
        line_write(LINE_WINDOW_ADDR, data, '1);
        if (model_credits > 0) begin
            model_credits = model_credits - 1;
            exp_sum       = exp_sum + line_word_sum(data);
            exp_lines     = exp_lines + 1;
        end else begin
            exp_drops = exp_drops + 1;
        end
    endtask

    // Once the engine has taken every line, all credits are home again
    task automatic drain_fifo();
        wait_lines(exp_lines);
        model_credits = FIFO_DEPTH;
    endtask

    task automatic check_all_counts();
        word_t rd;
        csr_read(CSR_SUM, rd);
        check_word("CSR_SUM", rd, exp_sum);
        csr_read(CSR_LINES, rd);
        check_count("CSR_LINES", count_t'(rd), exp_lines);
        csr_read(CSR_DROPS, rd);
        check_count("CSR_DROPS", count_t'(rd), exp_drops);
        csr_read(CSR_REJECTS, rd);
        check_count("CSR_REJECTS", count_t'(rd), exp_rejects);
    endtask

    // ====================
    // Clock and timeout
    // ====================

    initial begin
        afu_clk = 1'b0;
        forever #4 afu_clk = ~afu_clk;
    end

    always @(posedge afu_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("The run timed out after %0d cycles", cycles);
            stop_on_failure();
        end
    end

    // ====================
    // Stimulus
    // ====================

    initial begin
        word_t      rd;
        word_t      wdata;
        word_t      scratch_exp;
        word_t      sum_before;
        count_t     lines_before;
        word_be_t   be;
        line_be_t   lbe;
        line_addr_t bad_addr;
        mmio64_req    = '0;
        mmio512_wr    = '0;
        rst_n         = 1'b0;
        exp_sum       = '0;
        exp_lines     = '0;
        exp_drops     = '0;
        exp_rejects   = '0;
        model_credits = FIFO_DEPTH;
        repeat (10) @(negedge afu_clk);
        rst_n = 1'b1;

        // ID and scratch, with a partial byte-enable write at the end
        csr_read(CSR_ID, rd);
        check_word("CSR_ID", rd, AFU_ID);
        wdata = {$random(seed), $random(seed)};
        csr_write(CSR_SCRATCH, wdata, '1);
        scratch_exp = wdata;
        csr_read(CSR_SCRATCH, rd);
        check_word("CSR_SCRATCH", rd, scratch_exp);
        wdata = {$random(seed), $random(seed)};
        be    = $random(seed);
        if (&be || be == '0) be = 8'h5a;
        csr_write(CSR_SCRATCH, wdata, be);
        scratch_exp = merge_bytes(scratch_exp, wdata, be);
        csr_read(CSR_SCRATCH, rd);
        check_word("CSR_SCRATCH after partial write", rd, scratch_exp);

        // Running engine, drained whenever the model runs out of credits
        for (int i = 0; i < LINES_RUNNING; i++) begin
            send_line(random_line());
            if (model_credits == 0 || i == LINES_RUNNING - 1) drain_fifo();
        end
        check_all_counts();

        // Wrong addresses and partial lanes are rejected and never summed
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                bad_addr = $random(seed);
                if (bad_addr == LINE_WINDOW_ADDR) bad_addr = bad_addr + 1'b1;
                line_write(bad_addr, random_line(), '1);
            end else begin
                lbe    = {$random(seed), $random(seed)};
                lbe[i] = 1'b0;
                line_write(LINE_WINDOW_ADDR, random_line(), lbe);
            end
            exp_rejects = exp_rejects + 1;
        end
        check_all_counts();

        // Paused engine fills the FIFO, the surplus lines are dropped
        csr_write(CSR_CTRL, 64'h1, '1);
        sum_before   = exp_sum;
        lines_before = exp_lines;
        for (int i = 0; i < LINES_OVERFLOW; i++) begin
            send_line(random_line());
        end
        // Nothing leaves the FIFO yet, so only the drops have moved
        csr_read(CSR_SUM, rd);
        check_word("CSR_SUM while paused", rd, sum_before);
        csr_read(CSR_LINES, rd);
        check_count("CSR_LINES while paused", count_t'(rd), lines_before);
        csr_read(CSR_DROPS, rd);
        check_count("CSR_DROPS while paused", count_t'(rd), exp_drops);
        csr_write(CSR_CTRL, 64'h0, '1);
        drain_fifo();
        check_all_counts();

        // Clear zeroes the counters, a new line then sums from zero
        csr_write(CSR_CTRL, 64'h2, '1);
        exp_sum     = '0;
        exp_lines   = '0;
        exp_drops   = '0;
        exp_rejects = '0;
        check_all_counts();
        send_line(random_line());
        drain_fifo();
        check_all_counts();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: list.f
+incdir+tests
hdl/afu_pkg.sv
hdl/mmio512_ingress.sv
hdl/line_fifo.sv
hdl/line_sum_engine.sv
hdl/csr_mmio64.sv
hdl/mmio_afu_top.sv
tests/tb_mmio_afu.sv
